//--- Makefile
# Verilator build and run for the instruction cache refill testbench

VERILATOR ?= verilator
TOP ?= tb_icache_refill
FILELIST ?= compile.f
OBJ_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= NO ERRORS

SOURCES := $(shell cat $(FILELIST))
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the pass line shows up in the simulator output
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
hdl/icache_pkg.sv
hdl/icache_line_if.sv
hdl/refill_ctrl.sv
hdl/refill_assembler.sv
hdl/icache_store.sv
hdl/icache_refill_top.sv
tb/icache_refill_checker.sv
tb/tb_icache_refill.sv

//--- hdl/icache_line_if.sv
// Completed cache line transfer from the refill assembler to the store and controller
`timescale 1ns/100ps

interface icache_line_if import icache_pkg::*; ();

	// One-cycle write strobe, the other signals are only meaningful with it
	logic wr;
	// Virtual tag, physical tag and the four bundles
	icache_line_t line;
	// Set index taken from the virtual line address
	set_t vset;
	// Way picked by the assembler
	way_t way;
	// Refill slot that the line came from, so the controller can free it
	slot_t slot;

	// Assembler side drives everything
	modport src (
		output wr,
		output line,
		output vset,
		output way,
		output slot
	);

	// Store and controller only listen
	modport dst (
		input wr,
		input line,
		input vset,
		input way,
		input slot
	);

endinterface

//--- hdl/icache_pkg.sv
// Instruction cache refill package with address, tag, transaction id and line types
package icache_pkg;

	// ==============================
	// Geometry
	// ==============================
	localparam int ADDR_WIDTH       = 32;
	localparam int BUNDLE_WIDTH     = 128;
	localparam int BUNDLES_PER_LINE = 4;
	localparam int LINE_WIDTH       = BUNDLE_WIDTH * BUNDLES_PER_LINE;
	localparam int N_SLOTS          = 4;
	localparam int N_SETS           = 16;
	localparam int N_WAYS           = 4;

	// Byte address fields, a bundle is 16 bytes and a line is 64 bytes
	localparam int BUNDLE_LSB = 4;
	localparam int SET_LSB    = 6;
	localparam int TAG_LSB    = 10;
	localparam int TAG_WIDTH  = ADDR_WIDTH - TAG_LSB;

	// Way selection LFSR, x^17 + x^14 + 1
	localparam int LFSR_WIDTH = 17;
	localparam logic [LFSR_WIDTH-1:0] LFSR_SEED = 17'h00001;

	// ==============================
	// Types
	// ==============================
	typedef logic [ADDR_WIDTH-1:0] address_t;
	typedef logic [1:0] slot_t;
	typedef logic [1:0] bundle_t;
	// Slot number in the upper half, bundle number in the lower half
	typedef logic [3:0] tranid_t;
	typedef logic [3:0] set_t;
	typedef logic [1:0] way_t;
	typedef logic [TAG_WIDTH-1:0] tag_t;

	// Bundle 0 sits in the lowest bits of data
	typedef struct packed {
		tag_t vtag;
		tag_t ptag;
		logic [LINE_WIDTH-1:0] data;
	} icache_line_t;

	// ==============================
	// Address helpers
	// ==============================
	function automatic tag_t addr_tag(address_t a);
		return a[ADDR_WIDTH-1:TAG_LSB];
	endfunction

	function automatic set_t addr_set(address_t a);
		return a[TAG_LSB-1:SET_LSB];
	endfunction

	// Clears the byte offset within the line
	function automatic address_t line_base(address_t a);
		return {a[ADDR_WIDTH-1:SET_LSB], {SET_LSB{1'b0}}};
	endfunction

endpackage

//--- hdl/icache_refill_top.sv
// Instruction cache refill top level joining controller, assembler and store
`timescale 1ns/100ps

module icache_refill_top import icache_pkg::*; (
	input  logic clk,
	input  logic rst,
	// Miss request from fetch
	input  logic miss,
	input  address_t miss_vadr,
	input  address_t miss_padr,
	output logic miss_stall,
	// Split-transaction bus, request side
	output logic bus_req,
	output tranid_t bus_req_tid,
	output address_t bus_req_adr,
	// Split-transaction bus, response side
	input  logic bus_ack,
	input  tranid_t bus_tid,
	input  address_t bus_adr,
	input  logic [BUNDLE_WIDTH-1:0] bus_dat,
	// Fetch lookup
	input  logic fetch,
	input  address_t fetch_vadr,
	output logic fetch_hit,
	output logic [LINE_WIDTH-1:0] fetch_line,
	output tag_t fetch_ptag,
	output logic line_done
);

	// Virtual line address of every slot, owned by the controller
	address_t slot_vadr [N_SLOTS];

	icache_line_if line_if ();

	refill_ctrl u_ctrl (
		.clk(clk),
		.rst(rst),
		.miss(miss),
		.miss_vadr(miss_vadr),
		.miss_padr(miss_padr),
		.miss_stall(miss_stall),
		.bus_req(bus_req),
		.bus_req_tid(bus_req_tid),
		.bus_req_adr(bus_req_adr),
		.slot_vadr(slot_vadr),
		.done(line_if.dst)
	);

	refill_assembler u_asm (
		.clk(clk),
		.rst(rst),
		.bus_ack(bus_ack),
		.bus_tid(bus_tid),
		.bus_adr(bus_adr),
		.bus_dat(bus_dat),
		.slot_vadr(slot_vadr),
		.line_out(line_if.src)
	);

	icache_store u_store (
		.clk(clk),
		.rst(rst),
		.line_in(line_if.dst),
		.fetch(fetch),
		.fetch_vadr(fetch_vadr),
		.fetch_hit(fetch_hit),
		.fetch_line(fetch_line),
		.fetch_ptag(fetch_ptag)
	);

	// The store writes on the edge that ends this pulse
	assign line_done = line_if.wr;

endmodule

//--- hdl/icache_store.sv
// Instruction cache store with tag and data arrays, line write and registered lookup
`timescale 1ns/100ps

module icache_store import icache_pkg::*; (
	input  logic clk,
	input  logic rst,
	icache_line_if.dst line_in,
	input  logic fetch,
	input  address_t fetch_vadr,
	output logic fetch_hit,
	output logic [LINE_WIDTH-1:0] fetch_line,
	output tag_t fetch_ptag
);

	// ==============================
	// Arrays
	// ==============================
	logic [N_WAYS-1:0] tag_v [N_SETS];
	tag_t vtag_mem [N_SETS][N_WAYS];
	tag_t ptag_mem [N_SETS][N_WAYS];
	logic [LINE_WIDTH-1:0] data_mem [N_SETS][N_WAYS];

	// Lookup signals
	set_t lk_set;
	tag_t lk_tag;
	logic [N_WAYS-1:0] way_match;
	logic lk_hit;
	way_t lk_way;

	// The cache is indexed and tagged with the virtual address
	assign lk_set = addr_set(fetch_vadr);
	assign lk_tag = addr_tag(fetch_vadr);

	// Compare all ways of the set at once
	always_comb begin
		for (int w = 0; w < N_WAYS; w++)
			way_match[w] = tag_v[lk_set][w] && (vtag_mem[lk_set][w] == lk_tag);
	end
	assign lk_hit = |way_match;

	// Two ways only share a tag after a repeated refill of the same line,
	// and then both hold the same bytes, so the lowest one will do
	always_comb begin
		lk_way = '0;
		for (int w = N_WAYS - 1; w >= 0; w--)
			if (way_match[w])
				lk_way = way_t'(w);
	end

	// ==============================
	// Valid bits and hit flag
	// ==============================
	always_ff @(posedge clk, posedge rst)
	if (rst) begin
		for (int s = 0; s < N_SETS; s++)
			tag_v[s] <= '0;
		fetch_hit <= 1'b0;
	end
	else begin
		if (line_in.wr)
			tag_v[line_in.vset][line_in.way] <= 1'b1;
		// No fetch in the previous cycle means no hit
		fetch_hit <= fetch & lk_hit;
	end

	// ==============================
	// Tag and data arrays
	// ==============================
	// A write fills one whole way, tags and data together
	always_ff @(posedge clk) begin
		if (line_in.wr) begin
			vtag_mem[line_in.vset][line_in.way] <= line_in.line.vtag;
			ptag_mem[line_in.vset][line_in.way] <= line_in.line.ptag;
			data_mem[line_in.vset][line_in.way] <= line_in.line.data;
		end
	end

	// Lookup results are registered one cycle after the fetch strobe
	always_ff @(posedge clk) begin
		if (fetch) begin
			fetch_line <= data_mem[lk_set][lk_way];
			fetch_ptag <= ptag_mem[lk_set][lk_way];
		end
	end

endmodule

//--- hdl/refill_assembler.sv
// Refill assembler that gathers out of order bundles into lines and sends them to the store
`timescale 1ns/100ps

module refill_assembler import icache_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic bus_ack,
	input  tranid_t bus_tid,
	input  address_t bus_adr,
	input  logic [BUNDLE_WIDTH-1:0] bus_dat,
	input  address_t slot_vadr [N_SLOTS],
	icache_line_if.src line_out
);

	// Per-slot line buffers
	logic [BUNDLE_WIDTH-1:0] bnd_dat [N_SLOTS][BUNDLES_PER_LINE];
	logic [BUNDLES_PER_LINE-1:0] bnd_v [N_SLOTS];
	tag_t buf_vtag [N_SLOTS];
	tag_t buf_ptag [N_SLOTS];
	set_t buf_set [N_SLOTS];

	logic [LFSR_WIDTH-1:0] lfsr;
	slot_t ack_slot;
	bundle_t ack_bnd;
	logic send;
	slot_t send_slot;
	logic [LINE_WIDTH-1:0] send_data;

	// The transaction id tells where a response belongs, the address is
	// only used for the physical tag
	assign ack_slot = bus_tid[3:2];
	assign ack_bnd = bus_tid[1:0];

	// ==============================
	// Complete line search
	// ==============================
	// Scanning downwards leaves the lowest complete slot selected
	always_comb begin
		send = 1'b0;
		send_slot = '0;
		for (int s = N_SLOTS - 1; s >= 0; s--) begin
			if (&bnd_v[s]) begin
				send = 1'b1;
				send_slot = slot_t'(s);
			end
		end
	end

	// Bundle 0 lands in the lowest bits of the line
	always_comb begin
		send_data = '0;
		for (int b = 0; b < BUNDLES_PER_LINE; b++)
			send_data[b*BUNDLE_WIDTH +: BUNDLE_WIDTH] = bnd_dat[send_slot][b];
	end

	// ==============================
	// Control
	// ==============================
	always_ff @(posedge clk, posedge rst)
	if (rst) begin
		for (int s = 0; s < N_SLOTS; s++)
			bnd_v[s] <= '0;
		line_out.wr <= 1'b0;
		lfsr <= LFSR_SEED;
	end
	else begin
		// Free running, so the way depends on when a line happens to finish
		lfsr <= {lfsr[LFSR_WIDTH-2:0], lfsr[16] ^ lfsr[13]};
		line_out.wr <= send;
		if (send)
			bnd_v[send_slot] <= '0;
		// The slot that just left cannot get an ack until it is reissued,
		// so these two never touch the same slot
		if (bus_ack)
			bnd_v[ack_slot][ack_bnd] <= 1'b1;
	end

	// ==============================
	// Data path
	// ==============================
	always_ff @(posedge clk) begin
		if (bus_ack) begin
			bnd_dat[ack_slot][ack_bnd] <= bus_dat;
			buf_ptag[ack_slot] <= addr_tag(bus_adr);
			// The controller holds the virtual address for as long as the slot is busy
			buf_vtag[ack_slot] <= addr_tag(slot_vadr[ack_slot]);
			buf_set[ack_slot] <= addr_set(slot_vadr[ack_slot]);
		end
		if (send) begin
			line_out.line.vtag <= buf_vtag[send_slot];
			line_out.line.ptag <= buf_ptag[send_slot];
			line_out.line.data <= send_data;
			line_out.vset <= buf_set[send_slot];
			line_out.way <= way_t'(lfsr[1:0]);
			line_out.slot <= send_slot;
		end
	end

endmodule

//--- hdl/refill_ctrl.sv
// Refill controller that allocates slots, queues misses and issues bundle reads
`timescale 1ns/100ps

module refill_ctrl import icache_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic miss,
	input  address_t miss_vadr,
	input  address_t miss_padr,
	output logic miss_stall,
	output logic bus_req,
	output tranid_t bus_req_tid,
	output address_t bus_req_adr,
	output address_t slot_vadr [N_SLOTS],
	icache_line_if.dst done
);

	typedef enum logic {IDLE, BURST} state_t;

	logic [N_SLOTS-1:0] busy;
	address_t slot_padr [N_SLOTS];
	logic accept;
	slot_t free_slot;
	// Issue queue of accepted slots, never deeper than the slot count
	slot_t q_mem [N_SLOTS];
	slot_t q_rd;
	slot_t q_wr;
	logic [2:0] q_cnt;
	logic q_push;
	logic q_pop;
	logic bypass;
	// Burst state
	state_t state;
	slot_t cur_slot;
	bundle_t cur_bnd;
	// Request to be emitted on the next edge
	logic emit;
	slot_t e_slot;
	bundle_t e_bnd;
	address_t e_base;

	// ==============================
	// Slot allocation
	// ==============================
	assign miss_stall = &busy;
	assign accept = miss & ~miss_stall;

	// Lowest free slot wins
	always_comb begin
		free_slot = '0;
		for (int i = N_SLOTS - 1; i >= 0; i--)
			if (!busy[i])
				free_slot = slot_t'(i);
	end

	// ==============================
	// Issue selection
	// ==============================
	// An idle FSM takes the queue head first, a fresh miss goes straight out only
	// when nothing older is waiting
	always_comb begin
		q_pop = 1'b0;
		bypass = 1'b0;
		if (state == IDLE) begin
			if (q_cnt != 3'd0)
				q_pop = 1'b1;
			else if (accept)
				bypass = 1'b1;
		end
	end
	assign q_push = accept & ~bypass;
	assign emit = (state == BURST) | q_pop | bypass;

	always_comb begin
		if (state == BURST) begin
			e_slot = cur_slot;
			e_bnd = cur_bnd;
			e_base = slot_padr[cur_slot];
		end
		else if (q_pop) begin
			e_slot = q_mem[q_rd];
			e_bnd = '0;
			e_base = slot_padr[q_mem[q_rd]];
		end
		else begin
			// Bypass case, the slot registers are being written on this same edge
			e_slot = free_slot;
			e_bnd = '0;
			e_base = miss_padr;
		end
	end

	always_ff @(posedge clk, posedge rst)
	if (rst) begin
		busy <= '0;
		q_rd <= '0;
		q_wr <= '0;
		q_cnt <= '0;
		state <= IDLE;
		cur_slot <= '0;
		cur_bnd <= '0;
		bus_req <= 1'b0;
	end
	else begin
		// A finished line frees its slot, a new miss claims a different one
		if (done.wr)
			busy[done.slot] <= 1'b0;
		if (accept)
			busy[free_slot] <= 1'b1;
		if (q_push)
			q_wr <= q_wr + 1'b1;
		if (q_pop)
			q_rd <= q_rd + 1'b1;
		case ({q_push, q_pop})
		2'b10: q_cnt <= q_cnt + 1'b1;
		2'b01: q_cnt <= q_cnt - 1'b1;
		default: q_cnt <= q_cnt;
		endcase
		bus_req <= emit;
		// Bundle 0 goes out on entry, bundles 1 to 3 follow back to back
		if (state == IDLE) begin
			if (q_pop | bypass) begin
				state <= BURST;
				cur_slot <= e_slot;
				cur_bnd <= 2'd1;
			end
		end
		else begin
			cur_bnd <= cur_bnd + 1'b1;
			if (cur_bnd == 2'd3)
				state <= IDLE;
		end
	end

	// Per-slot addresses, queue storage and the request payload
	always_ff @(posedge clk) begin
		if (accept) begin
			slot_vadr[free_slot] <= line_base(miss_vadr);
			slot_padr[free_slot] <= line_base(miss_padr);
		end
		if (q_push)
			q_mem[q_wr] <= free_slot;
		if (emit) begin
			bus_req_tid <= {e_slot, e_bnd};
			bus_req_adr <= line_base(e_base) | (address_t'(e_bnd) << BUNDLE_LSB);
		end
	end

endmodule

//--- tb/icache_refill_checker.sv
// Concurrent protocol assertions for the instruction cache refill top level
`timescale 1ns/100ps

module icache_refill_checker import icache_pkg::*; (
	input logic clk,
	input logic rst,
	input logic miss,
	input logic miss_stall,
	input logic bus_req,
	input logic fetch,
	input logic fetch_hit,
	input logic line_done,
	input slot_t done_slot
);

	// One counter per assertion, summed for the testbench
	int fails_burst = 0;
	int fails_done = 0;
	int fails_hit = 0;
	int fails_stall = 0;
	int fail_count;
	// Bus reads still owed to accepted misses
	int credit;

	assign fail_count = fails_burst + fails_done + fails_hit + fails_stall;

	// Every accepted miss earns four bus reads, every read spends one
	always_ff @(posedge clk, posedge rst)
	if (rst)
		credit <= 0;
	else
		credit <= credit + ((miss && !miss_stall) ? 4 : 0) - (bus_req ? 1 : 0);

	// ==============================
	// Rules
	// ==============================
	assert property (@(posedge clk) disable iff (rst) bus_req |-> credit > 0)
	else begin
		$error("bus_req without an accepted miss left to serve");
		fails_burst++;
	end

	// A slot finishes once per refill
	assert property (@(posedge clk) disable iff (rst)
		line_done |=> !(line_done && done_slot == $past(done_slot)))
	else begin
		$error("line_done high twice in a row for one slot");
		fails_done++;
	end

	assert property (@(posedge clk) disable iff (rst) fetch_hit |-> $past(fetch))
	else begin
		$error("fetch_hit without a fetch in the previous cycle");
		fails_hit++;
	end

	// With no reads owed, a miss refused by the stall must not start a burst
	assert property (@(posedge clk) disable iff (rst)
		miss && miss_stall && credit == 0 |=> !bus_req)
	else begin
		$error("miss accepted while miss_stall is high");
		fails_stall++;
	end

endmodule

bind icache_refill_top icache_refill_checker checker_inst (
	.clk(clk),
	.rst(rst),
	.miss(miss),
	.miss_stall(miss_stall),
	.bus_req(bus_req),
	.fetch(fetch),
	.fetch_hit(fetch_hit),
	.line_done(line_done),
	.done_slot(line_if.slot)
);

//--- tb/tb_icache_refill.sv
// Directed testbench for the instruction cache refill path with an out of order bus model
`timescale 1ns/100ps

module tb_icache_refill import icache_pkg::*; ();

	// ==============================
	// Run constants
	// ==============================
	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 5;
	localparam int RESET_CYCLES = 16;
	localparam int N_TESTS = 5;
	localparam int CYCLES_PER_TEST = 2000;
	// Longest wait for any single DUT event
	localparam int WAIT_LIMIT = 500;
	localparam int unsigned SEED = 32'h357f_4be0;
	localparam address_t LINE_MASK = 32'hFFFF_FFC0;
	localparam logic [31:0] DATA_MASK = 32'hA5A5_0000;
	localparam set_t SAME_SET = 4'd9;

	logic clk;
	logic rst;
	logic miss;
	address_t miss_vadr;
	address_t miss_padr;
	logic miss_stall;
	logic bus_req;
	tranid_t bus_req_tid;
	address_t bus_req_adr;
	logic bus_ack;
	tranid_t bus_tid;
	address_t bus_adr;
	logic [BUNDLE_WIDTH-1:0] bus_dat;
	logic fetch;
	address_t fetch_vadr;
	logic fetch_hit;
	logic [LINE_WIDTH-1:0] fetch_line;
	tag_t fetch_ptag;
	logic line_done;

	// Every request seen on the bus, in issue order
	tranid_t req_tid [$];
	address_t req_adr [$];
	// Requests not yet answered
	tranid_t pend_tid [$];
	address_t pend_adr [$];
	int done_cnt = 0;
	// Holds back all responses so that slots pile up
	logic bus_hold = 1'b0;

	icache_refill_top icache_refill_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ==============================
	// Reporting and compare tasks
	// ==============================
	task automatic abort_run();
		$display("ERRORS FOUND");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic fail_plain(input string what);
		$display("Failure at %0t: %s", $time, what);
		abort_run();
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic check_line(input string name, input logic [LINE_WIDTH-1:0] got,
			input logic [LINE_WIDTH-1:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic check_tag(input string name, input tag_t got, input tag_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic check_tid(input string name, input tranid_t got, input tranid_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic check_adr(input string name, input address_t got, input address_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, got);
			abort_run();
		end
	endtask

	// ==============================
	// Data rule and address helpers
	// ==============================
	// Each 32-bit word carries its own byte address with the upper half scrambled
	function automatic logic [BUNDLE_WIDTH-1:0] bundle_data(input address_t adr);
		logic [BUNDLE_WIDTH-1:0] d;
		for (int i = 0; i < 4; i++)
			d[32 * i +: 32] = (adr + address_t'(4 * i)) ^ DATA_MASK;
		return d;
	endfunction

	// Whole line seen word by word from the line base upwards
	function automatic logic [LINE_WIDTH-1:0] expected_line(input address_t padr);
		logic [LINE_WIDTH-1:0] e;
		address_t base;
		base = padr & LINE_MASK;
		for (int k = 0; k < 16; k++)
			e[32 * k +: 32] = (base + address_t'(4 * k)) ^ DATA_MASK;
		return e;
	endfunction

	// Tags differ between tests so no earlier line can answer a later lookup
	function automatic address_t make_vadr(input int test_no, input int idx, input set_t set);
		return {tag_t'(test_no * 16 + idx), set, 6'($urandom_range(63, 0))};
	endfunction

	// ==============================
	// Bus model
	// ==============================
	// Outputs are sampled on the falling edge, the response goes out after the next rise
	initial begin : bus_model
		logic nxt_ack;
		tranid_t nxt_tid;
		address_t nxt_adr;
		int idx;
		bus_ack = 1'b0;
		bus_tid = '0;
		bus_adr = '0;
		bus_dat = '0;
		forever begin
			@(negedge clk);
			if (bus_req) begin
				req_tid.push_back(bus_req_tid);
				req_adr.push_back(bus_req_adr);
				pend_tid.push_back(bus_req_tid);
				pend_adr.push_back(bus_req_adr);
			end
			if (line_done)
				done_cnt++;
			nxt_ack = 1'b0;
			nxt_tid = '0;
			nxt_adr = '0;
			// Random gaps, and any outstanding read may be answered next
			if (!bus_hold && pend_tid.size() != 0 && $urandom_range(3, 0) != 0) begin
				idx = $urandom_range(pend_tid.size() - 1, 0);
				nxt_ack = 1'b1;
				nxt_tid = pend_tid[idx];
				nxt_adr = pend_adr[idx];
				pend_tid.delete(idx);
				pend_adr.delete(idx);
			end
			@(posedge clk);
			#DRIVE_DELAY;
			bus_ack = nxt_ack;
			bus_tid = nxt_tid;
			bus_adr = nxt_adr;
			bus_dat = bundle_data(nxt_adr);
		end
	end

	initial begin : watchdog
		repeat (RESET_CYCLES + N_TESTS * CYCLES_PER_TEST) @(posedge clk);
		$display("Watchdog expired after %0d cycles per test", CYCLES_PER_TEST);
		abort_run();
	end

	// ==============================
	// Stimulus tasks
	// ==============================
	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	// Offers a miss once a slot is free
	task automatic issue_miss(input address_t vadr, input address_t padr);
		int waited;
		waited = 0;
		while (miss_stall) begin
			next_cycle();
			waited++;
			if (waited > WAIT_LIMIT)
				fail_plain("miss_stall never fell");
		end
		miss = 1'b1;
		miss_vadr = vadr;
		miss_padr = padr;
		next_cycle();
		miss = 1'b0;
	endtask

	// Once every read of the busy slots is out, a miss offered under the stall
	// must be dropped and add no reads
	task automatic offer_stalled_miss(input int reads);
		int waited;
		waited = 0;
		while (req_tid.size() < reads) begin
			next_cycle();
			waited++;
			if (waited > WAIT_LIMIT)
				fail_plain("the bus reads of the held misses did not appear");
		end
		check_bit("miss_stall", miss_stall, 1'b1);
		miss = 1'b1;
		miss_vadr = $urandom;
		miss_padr = $urandom;
		next_cycle();
		miss = 1'b0;
		repeat (4) next_cycle();
		if (req_tid.size() != reads)
			fail_plain("a miss offered while miss_stall was high sent bus reads");
	endtask

	task automatic wait_lines(input int target);
		int waited;
		waited = 0;
		while (done_cnt < target) begin
			next_cycle();
			waited++;
			if (waited > WAIT_LIMIT)
				fail_plain("line_done did not arrive for every refill");
		end
	endtask

	// The four reads of one miss go out in bundle order from one slot
	task automatic check_requests(input int first, input address_t padr);
		int waited;
		slot_t slot;
		address_t base;
		waited = 0;
		while (req_tid.size() < first + BUNDLES_PER_LINE) begin
			next_cycle();
			waited++;
			if (waited > WAIT_LIMIT)
				fail_plain("the bus reads of a miss did not appear");
		end
		base = padr & LINE_MASK;
		slot = req_tid[first][3:2];
		for (int b = 0; b < BUNDLES_PER_LINE; b++) begin
			check_tid("bus_req_tid", req_tid[first + b], {slot, 2'(b)});
			check_adr("bus_req_adr", req_adr[first + b], base + address_t'(16 * b));
		end
	endtask

	// Any hit must carry the right line, must_hit also demands the hit
	task automatic lookup(input address_t vadr, input logic must_hit,
			input logic [LINE_WIDTH-1:0] exp_line, input tag_t exp_ptag);
		fetch = 1'b1;
		fetch_vadr = vadr;
		next_cycle();
		fetch = 1'b0;
		if (must_hit)
			check_bit("fetch_hit", fetch_hit, 1'b1);
		if (fetch_hit) begin
			check_line("fetch_line", fetch_line, exp_line);
			check_tag("fetch_ptag", fetch_ptag, exp_ptag);
		end
	endtask

	// ==============================
	// Tests
	// ==============================
	task automatic test_cold_fetch();
		for (int i = 0; i < 8; i++) begin
			fetch = 1'b1;
			fetch_vadr = $urandom;
			next_cycle();
			fetch = 1'b0;
			check_bit("fetch_hit", fetch_hit, 1'b0);
		end
	endtask

	task automatic test_single_refill();
		address_t vadr;
		address_t padr;
		int first;
		int lines;
		vadr = make_vadr(2, 0, 4'd3);
		padr = $urandom;
		first = req_tid.size();
		lines = done_cnt;
		issue_miss(vadr, padr);
		check_requests(first, padr);
		wait_lines(lines + 1);
		repeat (20) next_cycle();
		if (done_cnt != lines + 1) begin
			$display("FAILED at %0t: line_done pulses expected %0d, got %0d",
				$time, 1, done_cnt - lines);
			abort_run();
		end
		lookup(vadr, 1'b1, expected_line(padr), padr[31:TAG_LSB]);
		// The address still points at a valid line, but no fetch means no hit
		next_cycle();
		check_bit("fetch_hit", fetch_hit, 1'b0);
	endtask

	// Fills every slot with responses held back, then lets them come in mixed
	task automatic refill_batch(input int test_no, input int count);
		address_t vadr [N_SLOTS + 1];
		address_t padr [N_SLOTS + 1];
		int first;
		int lines;
		first = req_tid.size();
		lines = done_cnt;
		bus_hold = 1'b1;
		for (int i = 0; i < count; i++) begin
			vadr[i] = make_vadr(test_no, i, set_t'(i * 3 + test_no));
			padr[i] = $urandom;
			issue_miss(vadr[i], padr[i]);
			if (i == N_SLOTS - 1) begin
				check_bit("miss_stall", miss_stall, 1'b1);
				if (count > N_SLOTS)
					offer_stalled_miss(first + BUNDLES_PER_LINE * N_SLOTS);
				bus_hold = 1'b0;
			end
		end
		for (int i = 0; i < count; i++)
			check_requests(first + BUNDLES_PER_LINE * i, padr[i]);
		wait_lines(lines + count);
		for (int i = 0; i < count; i++)
			lookup(vadr[i], 1'b1, expected_line(padr[i]), padr[i][31:TAG_LSB]);
	endtask

	// A repeated random way may evict an older line, never the newest one
	task automatic test_same_set();
		address_t vadr [N_WAYS];
		address_t padr [N_WAYS];
		int lines;
		for (int i = 0; i < N_WAYS; i++) begin
			vadr[i] = make_vadr(5, i, SAME_SET);
			padr[i] = $urandom;
			lines = done_cnt;
			issue_miss(vadr[i], padr[i]);
			wait_lines(lines + 1);
		end
		for (int i = 0; i < N_WAYS; i++)
			lookup(vadr[i], i == N_WAYS - 1, expected_line(padr[i]), padr[i][31:TAG_LSB]);
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin : main
		int unsigned seed_ret;
		seed_ret = $urandom(SEED);
		rst = 1'b1;
		miss = 1'b0;
		miss_vadr = '0;
		miss_padr = '0;
		fetch = 1'b0;
		fetch_vadr = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;
		check_bit("miss_stall", miss_stall, 1'b0);
		check_bit("bus_req", bus_req, 1'b0);
		check_bit("line_done", line_done, 1'b0);
		check_bit("fetch_hit", fetch_hit, 1'b0);
		test_cold_fetch();
		test_single_refill();
		refill_batch(3, N_SLOTS);
		refill_batch(4, N_SLOTS + 1);
		test_same_set();
		repeat (4) next_cycle();
		if (icache_refill_top_inst.checker_inst.fail_count == 0) begin
			$display("NO ERRORS");
			$finish;
		end
		else begin
			$display("Assertion checker saw %0d failures",
				icache_refill_top_inst.checker_inst.fail_count);
			abort_run();
		end
	end

endmodule
